// ==== logic/i2c_proto_pkg.sv ====
package i2c_proto_pkg;

    localparam int PRESCALE_W = 16;

    // requests from the byte controller to the bit controller
    typedef enum logic [2:0] {
        CMD_IDLE,
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ,
        CMD_RESTART
    } bit_cmd_t;

    // phases of each command are consecutive, one prescale tick each
    typedef enum logic [4:0] {
        B_IDLE,
        B_START_A,
        B_START_B,
        B_START_C,
        B_START_D,
        B_START_E,
        B_STOP_A,
        B_STOP_B,
        B_STOP_C,
        B_STOP_D,
        B_WRITE_A,
        B_WRITE_B,
        B_WRITE_C,
        B_WRITE_D,
        B_READ_A,
        B_READ_B,
        B_READ_C,
        B_READ_D,
        B_RESTART_A,
        B_RESTART_B,
        B_RESTART_C,
        B_RESTART_D
    } bit_state_t;

endpackage

// ==== logic/i2c_regs_pkg.sv ====
package i2c_regs_pkg;

    localparam int ADR_W = 3;

    localparam logic [ADR_W-1:0] ADR_PRER_LO = 3'd0;
    localparam logic [ADR_W-1:0] ADR_PRER_HI = 3'd1;
    localparam logic [ADR_W-1:0] ADR_CTRL    = 3'd2;
    localparam logic [ADR_W-1:0] ADR_TXR_RXR = 3'd3;
    localparam logic [ADR_W-1:0] ADR_CMD_SR  = 3'd4;

    localparam int CTRL_EN  = 7;

    localparam int CMD_STA  = 7;
    localparam int CMD_STO  = 6;
    localparam int CMD_RD   = 5;
    localparam int CMD_WR   = 4;
    localparam int CMD_ACK  = 3;

    localparam int SR_RXACK = 7;
    localparam int SR_BUSY  = 6;
    localparam int SR_AL    = 5;
    localparam int SR_TIP   = 1;

    typedef struct packed {
        logic       sta;
        logic       sto;
        logic       rd;
        logic       wr;
        logic       ack;    // 1 = nack after read
        logic [7:0] txd;
    } byte_req_t;

endpackage

// ==== logic/i2c_bit_if.sv ====
`timescale 1ns/100ps

interface i2c_bit_if;
    import i2c_proto_pkg::*;

    bit_cmd_t cmd;
    logic     cmd_ack;
    logic     din;
    logic     dout;
    logic     arblost;      // replaces cmd_ack on abort
    logic     busy;

    modport master (
        output cmd,
        output din,
        input  cmd_ack,
        input  dout,
        input  arblost,
        input  busy
    );

    modport slave (
        input  cmd,
        input  din,
        output cmd_ack,
        output dout,
        output arblost,
        output busy
    );

endinterface

// ==== logic/i2c_reg_decode.sv ====
`timescale 1ns/100ps

module i2c_reg_decode (
    input  logic                                 i_sysclk,
    input  logic                                 i_nReset,
    input  logic                                 i_wb_cyc,
    input  logic                                 i_wb_stb,
    input  logic                                 i_wb_we,
    input  logic [i2c_regs_pkg::ADR_W-1:0]       i_wb_adr,
    input  logic [7:0]                           i_wb_dat,
    input  logic                                 i_done,
    input  logic [7:0]                           i_rxd,
    input  logic                                 i_rxack,
    input  logic                                 i_al,
    input  logic                                 i_busy,
    output logic [7:0]                           o_wb_dat,
    output logic                                 o_wb_ack,
    output logic [i2c_proto_pkg::PRESCALE_W-1:0] o_prescale,
    output logic                                 o_enable,
    output i2c_regs_pkg::byte_req_t              o_req,
    output logic                                 o_req_valid
);
    import i2c_regs_pkg::*;

    logic [7:0] ctrl;
    logic [7:0] txr;
    logic [7:0] rxr;
    logic [7:0] status;
    logic [7:0] rd_dat;
    logic       wb_go;
    logic       wr_go;
    logic       cmd_go;
    logic       tip;
    logic       al;
    logic       rxack;

    assign o_enable = ctrl[CTRL_EN];
    assign wb_go    = i_wb_cyc & i_wb_stb & ~o_wb_ack;    // ack lags one cycle
    assign wr_go    = wb_go & i_wb_we;
    assign cmd_go   = wr_go && (i_wb_adr == ADR_CMD_SR) && o_enable && !tip &&
                      (i_wb_dat[CMD_STA] | i_wb_dat[CMD_STO] |
                       i_wb_dat[CMD_RD] | i_wb_dat[CMD_WR]);

    always_comb begin
        status           = '0;
        status[SR_RXACK] = rxack;
        status[SR_BUSY]  = i_busy;
        status[SR_AL]    = al;
        status[SR_TIP]   = tip;
    end

    always_comb begin
        case (i_wb_adr)
            ADR_PRER_LO: rd_dat = o_prescale[7:0];
            ADR_PRER_HI: rd_dat = o_prescale[15:8];
            ADR_CTRL:    rd_dat = ctrl;
            ADR_TXR_RXR: rd_dat = rxr;
            ADR_CMD_SR:  rd_dat = status;
            default:     rd_dat = 8'h00;
        endcase
    end

    always_ff @(posedge i_sysclk or negedge i_nReset) begin
        if (!i_nReset) begin
            o_wb_ack    <= 1'b0;
            o_req_valid <= 1'b0;
            o_prescale  <= '1;
            ctrl        <= 8'h00;
            tip         <= 1'b0;
            al          <= 1'b0;
            rxack       <= 1'b0;
        end else begin
            o_wb_ack    <= wb_go;
            o_req_valid <= cmd_go;
            if (wr_go) begin
                case (i_wb_adr)
                    ADR_PRER_LO: o_prescale[7:0]  <= i_wb_dat;
                    ADR_PRER_HI: o_prescale[15:8] <= i_wb_dat;
                    ADR_CTRL:    ctrl             <= i_wb_dat;
                    default:     ;
                endcase
            end
            if (cmd_go)
                tip <= 1'b1;
            else if (i_done || i_al || !o_enable)
                tip <= 1'b0;
            if (cmd_go)
                al <= 1'b0;                 // cleared by next command
            else if (i_al)
                al <= 1'b1;
            if (i_done)
                rxack <= i_rxack;
        end
    end

    always_ff @(posedge i_sysclk) begin
        if (wb_go)
            o_wb_dat <= rd_dat;
        if (wr_go && i_wb_adr == ADR_TXR_RXR)
            txr <= i_wb_dat;
        if (i_done)
            rxr <= i_rxd;
        if (cmd_go) begin
            o_req.sta <= i_wb_dat[CMD_STA];
            o_req.sto <= i_wb_dat[CMD_STO];
            o_req.rd  <= i_wb_dat[CMD_RD];
            o_req.wr  <= i_wb_dat[CMD_WR];
            o_req.ack <= i_wb_dat[CMD_ACK];
            o_req.txd <= txr;
        end
    end

endmodule

// ==== logic/i2c_byte_ctl.sv ====
`timescale 1ns/100ps

module i2c_byte_ctl (
    input  logic                    i_sysclk,
    input  logic                    i_nReset,
    input  logic                    i_enable,
    input  i2c_regs_pkg::byte_req_t i_req,
    input  logic                    i_req_valid,
    output logic                    o_done,
    output logic [7:0]              o_rxd,
    output logic                    o_rxack,
    output logic                    o_al,
    i2c_bit_if.master               bit_if
);
    import i2c_proto_pkg::*;
    import i2c_regs_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_ACK,
        ST_STOP
    } state_t;

    state_t     state;
    byte_req_t  req_q;
    logic [7:0] shreg;
    logic [2:0] bit_cnt;
    logic       accept;

    assign accept = (state == ST_IDLE) && i_req_valid;
    assign o_rxd  = shreg;
    assign bit_if.din = (state == ST_ACK) ? req_q.ack : shreg[7];    // msb first

    // bit command follows the state directly
    always_comb begin
        case (state)
            ST_START: bit_if.cmd = CMD_START;
            ST_DATA:  bit_if.cmd = req_q.wr ? CMD_WRITE : CMD_READ;
            ST_ACK:   bit_if.cmd = req_q.wr ? CMD_READ : CMD_WRITE;
            ST_STOP:  bit_if.cmd = CMD_STOP;
            default:  bit_if.cmd = CMD_IDLE;
        endcase
    end

    always_ff @(posedge i_sysclk or negedge i_nReset) begin
        if (!i_nReset) begin
            state   <= ST_IDLE;
            bit_cnt <= 3'd0;
            o_done  <= 1'b0;
            o_al    <= 1'b0;
            o_rxack <= 1'b0;
        end else if (!i_enable) begin
            state  <= ST_IDLE;
            o_done <= 1'b0;
            o_al   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            o_al   <= 1'b0;
            if (bit_if.arblost) begin
                state <= ST_IDLE;       // abort whatever was running
                o_al  <= 1'b1;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (accept) begin
                            bit_cnt <= 3'd7;
                            if (i_req.sta)
                                state <= ST_START;
                            else if (i_req.rd || i_req.wr)
                                state <= ST_DATA;
                            else
                                state <= ST_STOP;   // stop only
                        end
                    end
                    ST_START: begin
                        if (bit_if.cmd_ack) begin
                            if (req_q.rd || req_q.wr) begin
                                state <= ST_DATA;
                            end else if (req_q.sto) begin
                                state <= ST_STOP;
                            end else begin
                                state  <= ST_IDLE;
                                o_done <= 1'b1;
                            end
                        end
                    end
                    ST_DATA: begin
                        if (bit_if.cmd_ack) begin
                            bit_cnt <= bit_cnt - 1'b1;
                            if (bit_cnt == 3'd0)
                                state <= ST_ACK;
                        end
                    end
                    ST_ACK: begin
                        if (bit_if.cmd_ack) begin
                            o_rxack <= bit_if.dout;
                            if (req_q.sto) begin
                                state <= ST_STOP;
                            end else begin
                                state  <= ST_IDLE;
                                o_done <= 1'b1;
                            end
                        end
                    end
                    ST_STOP: begin
                        if (bit_if.cmd_ack) begin
                            state  <= ST_IDLE;
                            o_done <= 1'b1;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge i_sysclk) begin
        if (accept) begin
            req_q <= i_req;
            shreg <= i_req.txd;
        end else if (state == ST_DATA && bit_if.cmd_ack) begin
            shreg <= {shreg[6:0], bit_if.dout};     // tx out, rx in
        end
    end

endmodule

// ==== logic/i2c_bit_ctl.sv ====
`timescale 1ns/100ps

module i2c_bit_ctl (
    input  logic                                 i_sysclk,
    input  logic                                 i_nReset,
    input  logic                                 i_enable,
    input  logic [i2c_proto_pkg::PRESCALE_W-1:0] i_prescale,
    input  logic                                 i_scl,
    input  logic                                 i_sda,
    output logic                                 o_scl_oen,
    output logic                                 o_sda_oen,
    i2c_bit_if.slave                             bit_if
);
    import i2c_proto_pkg::*;

    bit_state_t            state;
    bit_state_t            state_nxt;
    logic [PRESCALE_W-1:0] cnt;
    logic                  tick;
    logic                  last;
    logic                  lost;
    logic                  scl_nxt;
    logic                  sda_nxt;
    logic                  chk_nxt;
    logic                  sda_chk;
    logic                  scl_s;
    logic                  sda_s;
    logic                  sda_d;

    assign tick      = (cnt == '0);
    assign last      = state inside {B_START_E, B_STOP_D, B_WRITE_D, B_READ_D, B_RESTART_D};
    assign state_nxt = last ? B_IDLE : bit_state_t'(state + 5'd1);
    assign lost      = sda_chk & o_sda_oen & ~sda_s;     // released but held low

    // phase counter, restarts with each command
    always_ff @(posedge i_sysclk or negedge i_nReset) begin
        if (!i_nReset)
            cnt <= '0;
        else if (!i_enable || state == B_IDLE || tick)
            cnt <= i_prescale;
        else
            cnt <= cnt - 1'b1;
    end

    // line levels set at the tick that ends each phase: scl, sda, check
    always_comb begin
        case (state)
            B_START_A:   {scl_nxt, sda_nxt, chk_nxt} = {o_scl_oen, 2'b10};
            B_START_B:   {scl_nxt, sda_nxt, chk_nxt} = 3'b110;
            B_START_C:   {scl_nxt, sda_nxt, chk_nxt} = 3'b100;   // start edge
            B_START_D:   {scl_nxt, sda_nxt, chk_nxt} = 3'b100;
            B_START_E:   {scl_nxt, sda_nxt, chk_nxt} = 3'b000;
            B_STOP_A:    {scl_nxt, sda_nxt, chk_nxt} = 3'b000;
            B_STOP_B:    {scl_nxt, sda_nxt, chk_nxt} = 3'b100;
            B_STOP_C:    {scl_nxt, sda_nxt, chk_nxt} = 3'b111;   // stop edge
            B_STOP_D:    {scl_nxt, sda_nxt, chk_nxt} = 3'b110;
            B_WRITE_A:   {scl_nxt, sda_nxt, chk_nxt} = {1'b0, bit_if.din, 1'b0};
            B_WRITE_B:   {scl_nxt, sda_nxt, chk_nxt} = {1'b1, bit_if.din, 1'b0};
            B_WRITE_C:   {scl_nxt, sda_nxt, chk_nxt} = {1'b1, bit_if.din, 1'b1};
            B_WRITE_D:   {scl_nxt, sda_nxt, chk_nxt} = {1'b0, bit_if.din, 1'b0};
            B_READ_A:    {scl_nxt, sda_nxt, chk_nxt} = 3'b010;
            B_READ_B:    {scl_nxt, sda_nxt, chk_nxt} = 3'b110;
            B_READ_C:    {scl_nxt, sda_nxt, chk_nxt} = 3'b110;
            B_READ_D:    {scl_nxt, sda_nxt, chk_nxt} = 3'b010;
            B_RESTART_A: {scl_nxt, sda_nxt, chk_nxt} = 3'b010;
            B_RESTART_B: {scl_nxt, sda_nxt, chk_nxt} = 3'b111;
            B_RESTART_C: {scl_nxt, sda_nxt, chk_nxt} = 3'b100;
            B_RESTART_D: {scl_nxt, sda_nxt, chk_nxt} = 3'b000;
            default:     {scl_nxt, sda_nxt, chk_nxt} = 3'b110;
        endcase
    end

    always_ff @(posedge i_sysclk or negedge i_nReset) begin
        if (!i_nReset) begin
            state          <= B_IDLE;
            o_scl_oen      <= 1'b1;
            o_sda_oen      <= 1'b1;
            sda_chk        <= 1'b0;
            bit_if.cmd_ack <= 1'b0;
            bit_if.arblost <= 1'b0;
        end else if (!i_enable) begin
            state          <= B_IDLE;
            o_scl_oen      <= 1'b1;
            o_sda_oen      <= 1'b1;
            sda_chk        <= 1'b0;
            bit_if.cmd_ack <= 1'b0;
            bit_if.arblost <= 1'b0;
        end else begin
            bit_if.cmd_ack <= 1'b0;
            bit_if.arblost <= 1'b0;
            if (state == B_IDLE) begin
                sda_chk <= 1'b0;
                // skip the cycle where the old command is still presented
                if (!bit_if.cmd_ack && !bit_if.arblost) begin
                    case (bit_if.cmd)
                        CMD_START:   state <= B_START_A;
                        CMD_STOP:    state <= B_STOP_A;
                        CMD_WRITE:   state <= B_WRITE_A;
                        CMD_READ:    state <= B_READ_A;
                        CMD_RESTART: state <= B_RESTART_A;
                        default:     state <= B_IDLE;
                    endcase
                end
            end else if (tick) begin
                if (lost) begin
                    state          <= B_IDLE;
                    o_scl_oen      <= 1'b1;
                    o_sda_oen      <= 1'b1;
                    sda_chk        <= 1'b0;
                    bit_if.arblost <= 1'b1;
                end else begin
                    state          <= state_nxt;
                    o_scl_oen      <= scl_nxt;
                    o_sda_oen      <= sda_nxt;
                    sda_chk        <= chk_nxt;
                    bit_if.cmd_ack <= last;
                end
            end
        end
    end

    // bus watcher for start/stop, independent of our own commands
    always_ff @(posedge i_sysclk or negedge i_nReset) begin
        if (!i_nReset) begin
            scl_s       <= 1'b1;
            sda_s       <= 1'b1;
            sda_d       <= 1'b1;
            bit_if.busy <= 1'b0;
        end else begin
            scl_s <= i_scl;
            sda_s <= i_sda;
            sda_d <= sda_s;
            if (!i_enable)
                bit_if.busy <= 1'b0;
            else if (scl_s && sda_d && !sda_s)
                bit_if.busy <= 1'b1;        // start seen
            else if (scl_s && !sda_d && sda_s)
                bit_if.busy <= 1'b0;        // stop seen
        end
    end

    always_ff @(posedge i_sysclk) begin
        if (tick && (state == B_READ_C || state == B_WRITE_C))
            bit_if.dout <= sda_s;           // end of scl high
    end

endmodule

// ==== logic/i2c_master_top.sv ====
`timescale 1ns/100ps

module i2c_master_top (
    input  logic                           i_sysclk,
    input  logic                           i_nReset,
    input  logic                           i_wb_cyc,
    input  logic                           i_wb_stb,
    input  logic                           i_wb_we,
    input  logic [i2c_regs_pkg::ADR_W-1:0] i_wb_adr,
    input  logic [7:0]                     i_wb_dat,
    output logic [7:0]                     o_wb_dat,
    output logic                           o_wb_ack,
    input  logic                           i_scl,
    input  logic                           i_sda,
    output logic                           o_scl_oen,
    output logic                           o_sda_oen
);
    import i2c_proto_pkg::*;
    import i2c_regs_pkg::*;

    logic [PRESCALE_W-1:0] prescale;
    logic                  enable;
    byte_req_t             req;
    logic                  req_valid;
    logic                  done;
    logic [7:0]            rxd;
    logic                  rxack;
    logic                  al;

    i2c_bit_if bit_if ();

    i2c_reg_decode i2c_reg_decode_i (
        .i_sysclk    (i_sysclk),
        .i_nReset    (i_nReset),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_we     (i_wb_we),
        .i_wb_adr    (i_wb_adr),
        .i_wb_dat    (i_wb_dat),
        .i_done      (done),
        .i_rxd       (rxd),
        .i_rxack     (rxack),
        .i_al        (al),
        .i_busy      (bit_if.busy),
        .o_wb_dat    (o_wb_dat),
        .o_wb_ack    (o_wb_ack),
        .o_prescale  (prescale),
        .o_enable    (enable),
        .o_req       (req),
        .o_req_valid (req_valid)
    );

    i2c_byte_ctl i2c_byte_ctl_i (
        .i_sysclk    (i_sysclk),
        .i_nReset    (i_nReset),
        .i_enable    (enable),
        .i_req       (req),
        .i_req_valid (req_valid),
        .o_done      (done),
        .o_rxd       (rxd),
        .o_rxack     (rxack),
        .o_al        (al),
        .bit_if      (bit_if)
    );

    i2c_bit_ctl i2c_bit_ctl_i (
        .i_sysclk    (i_sysclk),
        .i_nReset    (i_nReset),
        .i_enable    (enable),
        .i_prescale  (prescale),
        .i_scl       (i_scl),
        .i_sda       (i_sda),
        .o_scl_oen   (o_scl_oen),
        .o_sda_oen   (o_sda_oen),
        .bit_if      (bit_if)
    );

endmodule

// ==== sim/i2c_master_asserts.sv ====
`timescale 1ns/100ps

module i2c_master_asserts (
    input logic                      i_sysclk,
    input logic                      i_nReset,
    input logic                      i_wb_cyc,
    input logic                      i_wb_stb,
    input logic                      i_wb_ack,
    input logic                      i_scl,
    input logic                      i_sda,
    input logic                      i_scl_oen,
    input logic                      i_sda_oen,
    input i2c_proto_pkg::bit_state_t i_bit_state,
    input logic                      i_req_sta,
    input logic                      i_busy,
    input logic                      i_al_flag
);
    import i2c_proto_pkg::*;

    int fail_cnt = 0;

    // lines released and no ack while in reset
    reset_idle: assert property (@(posedge i_sysclk)
        !i_nReset |-> i_scl_oen && i_sda_oen && !i_wb_ack)
        else begin $error("lines driven or ack high during reset"); fail_cnt++; end

    ack_follows_req: assert property (@(posedge i_sysclk) disable iff (!i_nReset)
        (i_wb_cyc && i_wb_stb && !i_wb_ack) |=> i_wb_ack)
        else begin $error("wishbone ack missing one cycle after request"); fail_cnt++; end

    ack_one_cycle: assert property (@(posedge i_sysclk) disable iff (!i_nReset)
        i_wb_ack |=> !i_wb_ack)
        else begin $error("wishbone ack longer than one cycle"); fail_cnt++; end

    ack_needs_req: assert property (@(posedge i_sysclk) disable iff (!i_nReset)
        i_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
        else begin $error("wishbone ack without request"); fail_cnt++; end

    // sda may only fall under high scl as a start, or rise as a stop
    sda_stable_scl_high: assert property (@(posedge i_sysclk) disable iff (!i_nReset)
        (i_scl && $past(i_scl) && (i_sda != $past(i_sda)))
            |-> (i_sda ? (i_bit_state == B_STOP_D)
                       : (i_bit_state inside {B_START_D, B_RESTART_D})))
        else begin $error("sda changed while scl high outside start or stop"); fail_cnt++; end

    start_before_data: assert property (@(posedge i_sysclk) disable iff (!i_nReset)
        (i_req_sta && $rose(i_bit_state == B_WRITE_A || i_bit_state == B_READ_A)) |-> i_busy)
        else begin $error("data bit without start on the bus"); fail_cnt++; end

    released_after_al: assert property (@(posedge i_sysclk) disable iff (!i_nReset)
        i_al_flag |-> i_scl_oen && i_sda_oen)
        else begin $error("lines still driven after lost arbitration"); fail_cnt++; end

endmodule

// ==== sim/i2c_master_tb.sv ====
`timescale 1ns/100ps

module i2c_master_tb;
    import i2c_regs_pkg::*;

    logic        clk;
    logic        n_reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [7:0]  wb_dat_w;
    logic [7:0]  wb_dat_r;
    logic        wb_ack;
    logic        scl_oen;
    logic        sda_oen;
    wire         scl;
    wire         sda;
    logic        slave_sda;
    logic        slave_read;
    int          force_bit;
    int          fall_cnt;
    int          rise_cnt;
    logic [7:0]  rd_sh;
    logic [8:0]  cap;
    int          mismatches;
    int          timeouts;
    int          assert_fails;
    integer      seed;
    logic [31:0] rnd;
    logic [7:0]  tx;
    logic [7:0]  rdat;

    assign scl = scl_oen;                   // no clock stretching
    assign sda = sda_oen & slave_sda;

    i2c_master_top i2c_master_top_i (
        .i_sysclk  (clk),
        .i_nReset  (n_reset),
        .i_wb_cyc  (wb_cyc),
        .i_wb_stb  (wb_stb),
        .i_wb_we   (wb_we),
        .i_wb_adr  (wb_adr),
        .i_wb_dat  (wb_dat_w),
        .o_wb_dat  (wb_dat_r),
        .o_wb_ack  (wb_ack),
        .i_scl     (scl),
        .i_sda     (sda),
        .o_scl_oen (scl_oen),
        .o_sda_oen (sda_oen)
    );

    bind i2c_master_top i2c_master_asserts asserts_i (
        .i_sysclk    (i_sysclk),
        .i_nReset    (i_nReset),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_ack    (o_wb_ack),
        .i_scl       (i_scl),
        .i_sda       (i_sda),
        .i_scl_oen   (o_scl_oen),
        .i_sda_oen   (o_sda_oen),
        .i_bit_state (i2c_bit_ctl_i.state),
        .i_req_sta   (i2c_byte_ctl_i.req_q.sta),
        .i_busy      (bit_if.busy),
        .i_al_flag   (i2c_reg_decode_i.al)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // start on the bus restarts the slave bit count
    always @(negedge sda) begin
        if (scl) begin
            fall_cnt = 0;
            rise_cnt = 0;
            rd_sh    = 8'hA5;
        end
    end

    always @(negedge scl) begin
        fall_cnt = fall_cnt + 1;
        if (fall_cnt == force_bit) begin
            slave_sda = 1'b0;               // arbitration attack
        end else if (slave_read && fall_cnt >= 1 && fall_cnt <= 8) begin
            slave_sda = rd_sh[7];
            rd_sh     = {rd_sh[6:0], 1'b0};
        end else if (!slave_read && fall_cnt == 9) begin
            slave_sda = 1'b0;               // ack
        end else begin
            slave_sda = 1'b1;
        end
    end

    always @(posedge scl) begin
        if (rise_cnt < 9) begin
            cap      = {cap[7:0], sda};
            rise_cnt = rise_cnt + 1;
        end
    end

    task automatic compare(input string what, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic wb_access(input logic we, input logic [2:0] adr, input logic [7:0] wdat,
                             output logic [7:0] data);
        int n;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack && n < 20);
        if (!wb_ack) begin
            timeouts++;
            $display("timeout: no wishbone ack at address %0d", adr);
        end
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wait_transfer(output logic [7:0] status);
        int n;
        n = 0;
        do begin
            wb_access(1'b0, ADR_CMD_SR, 8'h00, status);
            n++;
        end while (status[SR_TIP] && n < 500);
        if (status[SR_TIP]) begin
            timeouts++;
            $display("timeout: transfer in progress flag never cleared");
        end
    endtask

    initial begin
        seed = 32'hab48734b;
        n_reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 3'd0;
        wb_dat_w = 8'h00;
        slave_sda = 1'b1;
        slave_read = 1'b0;
        force_bit = 0;
        fall_cnt = 100;
        rise_cnt = 9;
        rd_sh = 8'hA5;
        cap = 9'h000;
        mismatches = 0;
        timeouts = 0;
        #1 n_reset = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        n_reset = 1'b1;

        wb_access(1'b1, ADR_PRER_LO, 8'h03, rdat);
        wb_access(1'b1, ADR_PRER_HI, 8'h00, rdat);
        wb_access(1'b1, ADR_CTRL, 8'h80, rdat);
        wb_access(1'b0, ADR_PRER_LO, 8'h00, rdat);
        compare("prescale low", rdat, 8'h03);
        wb_access(1'b0, ADR_PRER_HI, 8'h00, rdat);
        compare("prescale high", rdat, 8'h00);
        wb_access(1'b0, ADR_CTRL, 8'h00, rdat);
        compare("control", rdat, 8'h80);

        // write byte with start and stop
        rnd = $random(seed);
        tx  = rnd[7:0];
        wb_access(1'b1, ADR_TXR_RXR, tx, rdat);
        wb_access(1'b1, ADR_CMD_SR, 8'hD0, rdat);
        wait_transfer(rdat);
        compare("bits on sda", cap[8:1], tx);
        compare("status after write", rdat & 8'h82, 8'h00);

        // read byte twice with ack and nack
        slave_read = 1'b1;
        wb_access(1'b1, ADR_CMD_SR, 8'hE0, rdat);
        wait_transfer(rdat);
        wb_access(1'b0, ADR_TXR_RXR, 8'h00, rdat);
        compare("receive register", rdat, 8'hA5);
        compare("master ack bit", {7'd0, cap[0]}, 8'h00);
        wb_access(1'b1, ADR_CMD_SR, 8'hE8, rdat);
        wait_transfer(rdat);
        wb_access(1'b0, ADR_TXR_RXR, 8'h00, rdat);
        compare("receive register", rdat, 8'hA5);
        compare("master nack bit", {7'd0, cap[0]}, 8'h01);

        // slave pulls sda low on a 1 bit
        slave_read = 1'b0;
        force_bit  = 1;
        rnd = $random(seed);
        tx  = rnd[7:0] | 8'h80;
        wb_access(1'b1, ADR_TXR_RXR, tx, rdat);
        wb_access(1'b1, ADR_CMD_SR, 8'hD0, rdat);
        wait_transfer(rdat);
        compare("status after lost arbitration", rdat & 8'h22, 8'h20);
        repeat (20) @(negedge clk);

        assert_fails = i2c_master_top_i.asserts_i.fail_cnt;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, assert_fails);
        if (mismatches == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
logic/i2c_proto_pkg.sv
logic/i2c_regs_pkg.sv
logic/i2c_bit_if.sv
logic/i2c_reg_decode.sv
logic/i2c_byte_ctl.sv
logic/i2c_bit_ctl.sv
logic/i2c_master_top.sv
sim/i2c_master_asserts.sv
sim/i2c_master_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the I2C master testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module i2c_master_tb -o sim_i2c

out=$(./obj_dir/sim_i2c) || true
echo "$out"

echo "$out" | grep -qx "TESTBENCH PASSED"
